// ==== Bender.yml ====
package:
  name: vdiv

sources:
  - src/vdiv_pkg.sv
  - src/vdiv_step_if.sv
  - src/vdiv_ctrl_fsm.sv
  - src/vdiv_iter_counter.sv
  - src/vdiv_operand_prep.sv
  - src/vdiv_radix4_step.sv
  - src/vdiv_result_fix.sv
  - src/vdiv_top.sv
  - target: test
    include_dirs:
      - testbench
    files:
      - testbench/tb_vdiv.sv

// ==== compile.f ====
+incdir+testbench
src/vdiv_pkg.sv
src/vdiv_step_if.sv
src/vdiv_ctrl_fsm.sv
src/vdiv_iter_counter.sv
src/vdiv_operand_prep.sv
src/vdiv_radix4_step.sv
src/vdiv_result_fix.sv
src/vdiv_top.sv
testbench/tb_vdiv.sv

// ==== src/vdiv_ctrl_fsm.sv ====
// vector divider sequencer
// walks each lane through load, iterate and store, then finishes the vector

`timescale 1ns/1ps

module vdiv_ctrl_fsm (
    input  logic      clk_i,
    input  logic      rstn_i,
    input  logic      valid_i,
    input  logic      iter_last_i,
    input  logic      lane_last_i,
    output logic      busy_o,
    output logic      cnt_load_o,
    output logic      lane_next_o,
    output logic      store_o,
    output logic      finish_o,
    vdiv_step_if.ctrl step_if
);
    import vdiv_pkg::*;

    ctrl_state_e state_q;
    ctrl_state_e state_d;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // --------------------
    // next state
    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                // strobes are only seen here, so a busy unit drops them
                if (valid_i) begin
                    state_d = S_LOAD;
                end
            end
            S_LOAD:   state_d = S_ITER;
            S_ITER: begin
                if (iter_last_i) begin
                    state_d = S_STORE;
                end
            end
            // lowest lane done, go assemble the vector
            S_STORE:  state_d = lane_last_i ? S_FINISH : S_LOAD;
            S_FINISH: state_d = S_IDLE;
            default:  state_d = S_IDLE;
        endcase
    end

    // --------------------
    // decoded outputs
    assign busy_o       = (state_q != S_IDLE);
    assign cnt_load_o   = (state_q == S_LOAD);
    assign step_if.load = (state_q == S_LOAD);
    assign step_if.step = (state_q == S_ITER);
    // lane collected and index moved on the same edge
    assign store_o      = (state_q == S_STORE);
    assign lane_next_o  = (state_q == S_STORE);
    assign finish_o     = (state_q == S_FINISH);

endmodule

// ==== src/vdiv_iter_counter.sv ====
// vector divider counters
// lane index from the top lane down and radix-4 iterations per lane

`timescale 1ns/1ps

module vdiv_iter_counter #(
    parameter int DATA_W = vdiv_pkg::DATA_W_DEF
) (
    input  logic                clk_i,
    input  logic                rstn_i,
    input  logic                start_i,
    input  logic                cnt_load_i,
    input  logic                lane_next_i,
    input  vdiv_pkg::sew_e      sew_i,
    output vdiv_pkg::lane_idx_t lane_idx_o,
    output logic                iter_last_o,
    output logic                lane_last_o
);
    import vdiv_pkg::*;

    sew_e      sew_q;
    iter_cnt_t iter_q;
    lane_idx_t lane_q;

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            sew_q  <= SEW_8;
            iter_q <= '0;
            lane_q <= '0;
        end else begin
            // highest lane goes first
            if (start_i) begin
                sew_q  <= sew_i;
                lane_q <= lane_idx_t'(DATA_W / sew_width(sew_i) - 1);
            end else if (lane_next_i) begin
                lane_q <= lane_q - 1'b1;
            end
            // two quotient bits per step, so SEW/2 steps
            if (cnt_load_i) begin
                iter_q <= iter_cnt_t'(sew_width(sew_q) / 2 - 1);
            end else if (iter_q != '0) begin
                iter_q <= iter_q - 1'b1;
            end
        end
    end

    assign lane_idx_o  = lane_q;
    assign iter_last_o = (iter_q == '0);
    assign lane_last_o = (lane_q == '0);

endmodule

// ==== src/vdiv_operand_prep.sv ====
// vector divider operand prep
// splits both vectors into lanes, takes magnitudes, result signs and
// zero-divisor flags, then feeds the current lane to the step unit

`timescale 1ns/1ps

module vdiv_operand_prep #(
    parameter int DATA_W = vdiv_pkg::DATA_W_DEF
) (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            start_i,
    input  vdiv_pkg::vdiv_op_e              op_i,
    input  vdiv_pkg::sew_e                  sew_i,
    input  logic [DATA_W-1:0]               vs1_i,
    input  logic [DATA_W-1:0]               vs2_i,
    input  vdiv_pkg::lane_idx_t             lane_idx_i,
    vdiv_step_if.src                        step_if,
    output logic [vdiv_pkg::MAX_LANES-1:0]  neg_q_o,
    output logic [vdiv_pkg::MAX_LANES-1:0]  neg_r_o,
    output logic [vdiv_pkg::MAX_LANES-1:0]  zero_div_o,
    output logic [DATA_W-1:0]               dividend_raw_o,
    output vdiv_pkg::vdiv_op_e              op_o,
    output vdiv_pkg::sew_e                  sew_o
);
    import vdiv_pkg::*;

    logic                  signed_op;
    // one candidate per SEW, picked on start
    wire [3:0][DATA_W-1:0] mag1_all;
    wire [3:0][DATA_W-1:0] mag2_all;
    wire [3:0][MAX_LANES-1:0] negq_all;
    wire [3:0][MAX_LANES-1:0] negr_all;
    wire [3:0][MAX_LANES-1:0] zero_all;

    logic [DATA_W-1:0]     mag1_q;
    logic [DATA_W-1:0]     mag2_q;
    logic [DATA_W-1:0]     lane_mask;

    assign signed_op = (op_i == OP_DIV) || (op_i == OP_REM);

    // --------------------
    // per-SEW lane split
    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int W = 8 << s;
        localparam int N = DATA_W / W;
        for (genvar i = 0; i < MAX_LANES; i++) begin : g_lane
            if (i < N) begin : g_act
                logic [W-1:0] a;
                logic [W-1:0] b;
                // a is the dividend lane, b the divisor lane
                assign a = vs2_i[i*W +: W];
                assign b = vs1_i[i*W +: W];
                assign mag2_all[s][i*W +: W] = (signed_op && a[W-1]) ? -a : a;
                assign mag1_all[s][i*W +: W] = (signed_op && b[W-1]) ? -b : b;
                // quotient negative on differing signs, remainder follows dividend
                assign negq_all[s][i] = signed_op & (a[W-1] ^ b[W-1]);
                assign negr_all[s][i] = signed_op & a[W-1];
                assign zero_all[s][i] = (b == '0);
            end else begin : g_off
                assign negq_all[s][i] = 1'b0;
                assign negr_all[s][i] = 1'b0;
                assign zero_all[s][i] = 1'b0;
            end
        end
    end

    // --------------------
    // capture at the accepting edge
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            op_o       <= OP_DIVU;
            sew_o      <= SEW_8;
            neg_q_o    <= '0;
            neg_r_o    <= '0;
            zero_div_o <= '0;
        end else if (start_i) begin
            op_o       <= op_i;
            sew_o      <= sew_i;
            neg_q_o    <= negq_all[sew_i];
            neg_r_o    <= negr_all[sew_i];
            zero_div_o <= zero_all[sew_i];
        end
    end

    always_ff @(posedge clk_i) begin
        if (start_i) begin
            mag1_q         <= mag1_all[sew_i];
            mag2_q         <= mag2_all[sew_i];
            // raw dividend is the divide-by-zero remainder
            dividend_raw_o <= vs2_i;
        end
    end

    // current lane, shifted down and zero-extended
    assign lane_mask        = {DATA_W{1'b1}} >> (DATA_W - sew_width(sew_o));
    assign step_if.dividend = (mag2_q >> (lane_idx_i * sew_width(sew_o))) & lane_mask;
    assign step_if.divisor  = (mag1_q >> (lane_idx_i * sew_width(sew_o))) & lane_mask;

endmodule

// ==== src/vdiv_pkg.sv ====
// vector divider shared definitions
// element widths, divide opcodes, sequencer states and index types

package vdiv_pkg;

    // default vector width, one 64-bit register
    localparam int DATA_W_DEF = 64;
    // lane count at the narrowest element width
    localparam int MAX_LANES = DATA_W_DEF / 8;

    // element width select
    typedef enum logic [1:0] {
        SEW_8  = 2'd0,
        SEW_16 = 2'd1,
        SEW_32 = 2'd2,
        SEW_64 = 2'd3
    } sew_e;

    // signed and unsigned divide / remainder
    typedef enum logic [1:0] {
        OP_DIV  = 2'd0,
        OP_DIVU = 2'd1,
        OP_REM  = 2'd2,
        OP_REMU = 2'd3
    } vdiv_op_e;

    // lane sequencer states
    typedef enum logic [2:0] {
        S_IDLE   = 3'd0,
        S_LOAD   = 3'd1,
        S_ITER   = 3'd2,
        S_STORE  = 3'd3,
        S_FINISH = 3'd4
    } ctrl_state_e;

    // lane index, up to eight lanes
    typedef logic [2:0] lane_idx_t;
    // radix-4 iterations, 32 at most for 64-bit elements
    typedef logic [4:0] iter_cnt_t;

    // element width in bits for a given SEW code
    function automatic int unsigned sew_width(sew_e sew);
        return 32'd8 << sew;
    endfunction

endpackage

// ==== src/vdiv_radix4_step.sv ====
// vector divider radix-4 step
// restoring shift-subtract divider, two quotient bits per cycle

`timescale 1ns/1ps

module vdiv_radix4_step #(
    parameter int DATA_W = vdiv_pkg::DATA_W_DEF
) (
    input  logic           clk_i,
    input  logic           rstn_i,
    input  vdiv_pkg::sew_e sew_i,
    vdiv_step_if.core      step_if
);
    import vdiv_pkg::*;

    logic [DATA_W-1:0] rem_q;
    // dividend shifts out the top while quotient bits shift in below
    logic [DATA_W-1:0] dq_q;
    logic [DATA_W-1:0] div_q;

    logic [DATA_W-1:0] rem_n;
    logic [DATA_W-1:0] dq_n;
    // one extra bit so the shifted remainder never overflows
    logic [DATA_W:0]   trial;
    logic [DATA_W:0]   diff;

    // --------------------
    // two restoring iterations
    always_comb begin
        rem_n = rem_q;
        dq_n  = dq_q;
        trial = '0;
        diff  = '0;
        for (int k = 0; k < 2; k++) begin
            // next dividend bit sits at the top of the active element
            trial = {rem_n, dq_n[sew_width(sew_i) - 1]};
            diff  = trial - {1'b0, div_q};
            dq_n  = dq_n << 1;
            if (trial >= {1'b0, div_q}) begin
                rem_n   = diff[DATA_W-1:0];
                dq_n[0] = 1'b1;
            end else begin
                rem_n = trial[DATA_W-1:0];
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rem_q <= '0;
            dq_q  <= '0;
            div_q <= '0;
        end else if (step_if.load) begin
            // fresh lane, remainder starts empty
            rem_q <= '0;
            dq_q  <= step_if.dividend;
            div_q <= step_if.divisor;
        end else if (step_if.step) begin
            rem_q <= rem_n;
            dq_q  <= dq_n;
        end
    end

    // bits above the element in the quotient are don't-care
    assign step_if.quotient  = dq_q;
    assign step_if.remainder = rem_q;

endmodule

// ==== src/vdiv_result_fix.sv ====
// vector divider result assembly
// collects lane results, applies signs and divide-by-zero values,
// registers the vector and flags completion

`timescale 1ns/1ps

module vdiv_result_fix #(
    parameter int DATA_W = vdiv_pkg::DATA_W_DEF
) (
    input  logic                            clk_i,
    input  logic                            rstn_i,
    input  logic                            store_i,
    input  logic                            finish_i,
    input  vdiv_pkg::lane_idx_t             lane_idx_i,
    input  vdiv_pkg::sew_e                  sew_i,
    input  vdiv_pkg::vdiv_op_e              op_i,
    input  logic [vdiv_pkg::MAX_LANES-1:0]  neg_q_i,
    input  logic [vdiv_pkg::MAX_LANES-1:0]  neg_r_i,
    input  logic [vdiv_pkg::MAX_LANES-1:0]  zero_div_i,
    input  logic [DATA_W-1:0]               dividend_raw_i,
    vdiv_step_if.sink                       step_if,
    output logic [DATA_W-1:0]               vd_o,
    output logic                            done_o
);
    import vdiv_pkg::*;

    logic [DATA_W-1:0]     q_col_q;
    logic [DATA_W-1:0]     r_col_q;
    logic [DATA_W-1:0]     lane_mask;
    int unsigned           lane_sh;
    logic                  is_div;
    wire [3:0][DATA_W-1:0] q_fix_all;
    wire [3:0][DATA_W-1:0] r_fix_all;

    assign lane_mask = {DATA_W{1'b1}} >> (DATA_W - sew_width(sew_i));
    assign lane_sh   = lane_idx_i * sew_width(sew_i);
    assign is_div    = (op_i == OP_DIV) || (op_i == OP_DIVU);

    // --------------------
    // lane collector
    always_ff @(posedge clk_i) begin
        if (store_i) begin
            // clear the lane slot, then drop the new element in
            q_col_q <= (q_col_q & ~(lane_mask << lane_sh))
                     | ((step_if.quotient & lane_mask) << lane_sh);
            r_col_q <= (r_col_q & ~(lane_mask << lane_sh))
                     | ((step_if.remainder & lane_mask) << lane_sh);
        end
    end

    // --------------------
    // per-SEW sign and zero fix
    for (genvar s = 0; s < 4; s++) begin : g_sew
        localparam int W = 8 << s;
        localparam int N = DATA_W / W;
        for (genvar i = 0; i < N; i++) begin : g_lane
            logic [W-1:0] q;
            logic [W-1:0] r;
            assign q = q_col_q[i*W +: W];
            assign r = r_col_q[i*W +: W];
            // divide by zero: all ones quotient, dividend as remainder
            assign q_fix_all[s][i*W +: W] = zero_div_i[i] ? '1 : (neg_q_i[i] ? -q : q);
            assign r_fix_all[s][i*W +: W] = zero_div_i[i] ? dividend_raw_i[i*W +: W]
                                                          : (neg_r_i[i] ? -r : r);
        end
    end

    // --------------------
    // output register, held until the next finish
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            vd_o   <= '0;
            done_o <= 1'b0;
        end else begin
            done_o <= finish_i;
            if (finish_i) begin
                vd_o <= is_div ? q_fix_all[sew_i] : r_fix_all[sew_i];
            end
        end
    end

endmodule

// ==== src/vdiv_step_if.sv ====
// vector divider lane link
// carries one lane's magnitudes into the radix-4 step and its results out

`timescale 1ns/1ps

interface vdiv_step_if #(
    parameter int DATA_W = vdiv_pkg::DATA_W_DEF
);
    // step controls from the FSM
    logic              load;
    logic              step;
    // current lane magnitudes, zero-extended
    logic [DATA_W-1:0] dividend;
    logic [DATA_W-1:0] divisor;
    // running quotient and partial remainder
    logic [DATA_W-1:0] quotient;
    logic [DATA_W-1:0] remainder;

    modport ctrl (output load, output step);
    modport src  (output dividend, output divisor);
    modport core (
        input  load, step, dividend, divisor,
        output quotient, remainder
    );
    modport sink (input quotient, input remainder);

endinterface

// ==== src/vdiv_top.sv ====
// SIMD integer divider top level
// lane-serial vector divide and remainder at 8 to 64-bit elements,
// one shared radix-4 step, done strobe and busy flag

`timescale 1ns/1ps

module vdiv_top #(
    parameter int DATA_W = vdiv_pkg::DATA_W_DEF
) (
    input  logic               clk_i,
    input  logic               rstn_i,
    input  logic               valid_i,
    input  vdiv_pkg::vdiv_op_e op_i,
    input  vdiv_pkg::sew_e     sew_i,
    input  logic [DATA_W-1:0]  vs1_i,
    input  logic [DATA_W-1:0]  vs2_i,
    output logic               busy_o,
    output logic               done_o,
    output logic [DATA_W-1:0]  vd_o
);
    import vdiv_pkg::*;

    logic                 start;
    logic                 cnt_load;
    logic                 lane_next;
    logic                 store;
    logic                 finish;
    logic                 iter_last;
    logic                 lane_last;
    lane_idx_t            lane_idx;
    logic [MAX_LANES-1:0] neg_q;
    logic [MAX_LANES-1:0] neg_r;
    logic [MAX_LANES-1:0] zero_div;
    logic [DATA_W-1:0]    dividend_raw;
    vdiv_op_e             op_q;
    sew_e                 sew_q;

    vdiv_step_if #(.DATA_W(DATA_W)) step_if ();

    // accepted strobe, only while idle
    assign start = valid_i & ~busy_o;

    vdiv_ctrl_fsm u_ctrl (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .valid_i     (valid_i),
        .iter_last_i (iter_last),
        .lane_last_i (lane_last),
        .busy_o      (busy_o),
        .cnt_load_o  (cnt_load),
        .lane_next_o (lane_next),
        .store_o     (store),
        .finish_o    (finish),
        .step_if     (step_if.ctrl)
    );

    vdiv_iter_counter #(.DATA_W(DATA_W)) u_cnt (
        .clk_i       (clk_i),
        .rstn_i      (rstn_i),
        .start_i     (start),
        .cnt_load_i  (cnt_load),
        .lane_next_i (lane_next),
        .sew_i       (sew_i),
        .lane_idx_o  (lane_idx),
        .iter_last_o (iter_last),
        .lane_last_o (lane_last)
    );

    vdiv_operand_prep #(.DATA_W(DATA_W)) u_prep (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .start_i        (start),
        .op_i           (op_i),
        .sew_i          (sew_i),
        .vs1_i          (vs1_i),
        .vs2_i          (vs2_i),
        .lane_idx_i     (lane_idx),
        .step_if        (step_if.src),
        .neg_q_o        (neg_q),
        .neg_r_o        (neg_r),
        .zero_div_o     (zero_div),
        .dividend_raw_o (dividend_raw),
        .op_o           (op_q),
        .sew_o          (sew_q)
    );

    vdiv_radix4_step #(.DATA_W(DATA_W)) u_step (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .sew_i   (sew_q),
        .step_if (step_if.core)
    );

    vdiv_result_fix #(.DATA_W(DATA_W)) u_fix (
        .clk_i          (clk_i),
        .rstn_i         (rstn_i),
        .store_i        (store),
        .finish_i       (finish),
        .lane_idx_i     (lane_idx),
        .sew_i          (sew_q),
        .op_i           (op_q),
        .neg_q_i        (neg_q),
        .neg_r_i        (neg_r),
        .zero_div_i     (zero_div),
        .dividend_raw_i (dividend_raw),
        .step_if        (step_if.sink),
        .vd_o           (vd_o),
        .done_o         (done_o)
    );

endmodule

// ==== testbench/tb_vdiv_tasks.svh ====
// vector divider testbench helpers
// xorshift source, RISC-V divide model, request driving and compare tasks

// --------------------
// stimulus helpers
function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic logic [DATA_W-1:0] rand_vec();
    logic [DATA_W-1:0] v;
    v = '0;
    for (int k = 0; k < DATA_W / 32; k++) begin
        v = (v << 32) | DATA_W'(next_rand());
    end
    return v;
endfunction

function automatic int unsigned elem_bits(sew_e sew);
    case (sew)
        SEW_8:   return 8;
        SEW_16:  return 16;
        SEW_32:  return 32;
        default: return 64;
    endcase
endfunction

// lane value copied into every lane whose bit in sel is set
function automatic logic [DATA_W-1:0] lane_pattern(sew_e sew, logic [63:0] value,
                                                   logic [7:0] sel);
    int unsigned       w;
    logic [DATA_W-1:0] v;
    w = elem_bits(sew);
    v = '0;
    for (int i = 0; i < DATA_W / w; i++) begin
        if (sel[i]) begin
            v = v | ((value & ({64{1'b1}} >> (64 - w))) << (i * w));
        end
    end
    return v;
endfunction

// --------------------
// reference model
function automatic longint sign_extend(logic [63:0] v, int unsigned w);
    return longint'($signed(v << (64 - w)) >>> (64 - w));
endfunction

function automatic logic [63:0] model_lane(vdiv_op_e op, int unsigned w,
                                           logic [63:0] a, logic [63:0] b);
    logic [63:0] mask;
    logic [63:0] min_val;
    logic [63:0] res;
    longint      sa;
    longint      sb;
    mask    = {64{1'b1}} >> (64 - w);
    min_val = 64'd1 << (w - 1);
    a       = a & mask;
    b       = b & mask;
    sa      = sign_extend(a, w);
    sb      = sign_extend(b, w);
    if (b == 64'd0) begin
        // zero divisor gives all ones as quotient and the dividend as remainder
        res = (op == OP_DIV || op == OP_DIVU) ? mask : a;
    end else if ((op == OP_DIV || op == OP_REM) && a == min_val && b == mask) begin
        // most negative over minus one overflows
        res = (op == OP_DIV) ? min_val : 64'd0;
    end else begin
        case (op)
            OP_DIV:  res = sa / sb;
            OP_REM:  res = sa % sb;
            OP_DIVU: res = a / b;
            default: res = a % b;
        endcase
    end
    return res & mask;
endfunction

function automatic logic [DATA_W-1:0] model_vec(vdiv_op_e op, sew_e sew,
                                                logic [DATA_W-1:0] vs1_v,
                                                logic [DATA_W-1:0] vs2_v);
    int unsigned       w;
    logic [DATA_W-1:0] res;
    w   = elem_bits(sew);
    res = '0;
    // vs2 is the dividend, vs1 the divisor
    for (int i = 0; i < DATA_W / w; i++) begin
        res = res | (DATA_W'(model_lane(op, w, 64'(vs2_v >> (i * w)),
                                        64'(vs1_v >> (i * w)))) << (i * w));
    end
    return res;
endfunction

// lanes times (load + SEW/2 steps + store) plus the finish cycle
function automatic int expected_latency(sew_e sew);
    return (DATA_W / elem_bits(sew)) * (elem_bits(sew) / 2 + 2) + 1;
endfunction

// --------------------
// compare tasks
task automatic check_vec(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                         input string what);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("[ERROR] %0d ns: %s got %h, expected %h", $time, what, got, exp);
    end
endtask

task automatic check_latency(input int got, input int exp, input string what);
    check_count++;
    if (got != exp) begin
        err_count++;
        $display("[ERROR] %0d ns: %s got %0d cycles, expected %0d", $time, what, got, exp);
    end
endtask

task automatic check_flag(input logic got, input logic exp, input string what);
    check_count++;
    if (got !== exp) begin
        err_count++;
        $display("[ERROR] %0d ns: %s got %b, expected %b", $time, what, got, exp);
    end
endtask

// --------------------
// requests are entered and left on a falling edge
task automatic issue_request(input vdiv_op_e op_v, input sew_e sew_v,
                             input logic [DATA_W-1:0] vs1_v, input logic [DATA_W-1:0] vs2_v);
    req_op  = op_v;
    req_sew = sew_v;
    vs1     = vs1_v;
    vs2     = vs2_v;
    valid   = 1'b1;
    @(negedge clk);
    // one edge has sampled the strobe
    valid   = 1'b0;
endtask

// counts edges after the sampling edge until done_o shows up
task automatic wait_done(output int cycles, output logic busy_held);
    cycles    = 0;
    busy_held = 1'b1;
    while (!done && cycles < OP_TIMEOUT) begin
        if (!busy) begin
            busy_held = 1'b0;
        end
        @(negedge clk);
        cycles++;
    end
    if (!done) begin
        err_count++;
        $display("timeout: no done_o within %0d cycles of the request", OP_TIMEOUT);
    end
endtask

task automatic run_and_check(input vdiv_op_e op_v, input sew_e sew_v,
                             input logic [DATA_W-1:0] vs1_v, input logic [DATA_W-1:0] vs2_v,
                             input string tag);
    int   cycles;
    logic busy_held;
    issue_request(op_v, sew_v, vs1_v, vs2_v);
    wait_done(cycles, busy_held);
    check_latency(cycles, expected_latency(sew_v),
                  $sformatf("%s %s done_o delay", tag, op_v.name()));
    check_flag(busy_held, 1'b1, $sformatf("%s busy_o until done_o", tag));
    check_vec(vd, model_vec(op_v, sew_v, vs1_v, vs2_v),
              $sformatf("%s %s sew %0d", tag, op_v.name(), elem_bits(sew_v)));
endtask

task automatic report_test(input string name, input int unsigned chk0, input int unsigned err0);
    $display("%s: %0d checks, %0d errors", name, check_count - chk0, err_count - err0);
endtask

// ==== testbench/tb_vdiv.sv ====
// vector divider testbench
// directed checks of divide, remainder, divide by zero, latency and
// strobes that arrive while the unit is busy

`timescale 1ns/1ps

module tb_vdiv;
    import vdiv_pkg::*;

    localparam int DATA_W     = DATA_W_DEF;
    localparam int CLK_PERIOD = 10;
    localparam int RST_CYCLES = 5;
    localparam int ROUNDS     = 4;
    localparam int OP_TIMEOUT = 200;
    // requests per test, the busy test window counts as several
    localparam int TOTAL_OPS  = 4*ROUNDS*2 + 4*(ROUNDS*2 + 2) + 4*2*4 + 4 + 4;
    // slowest case is 8-bit elements
    localparam int MAX_LAT    = (DATA_W / 8) * (8 / 2 + 2) + 1;
    localparam int WATCHDOG_CYCLES = RST_CYCLES + 2 * TOTAL_OPS * (MAX_LAT + 2) + 500;

    logic              clk;
    logic              rstn;
    logic              valid;
    vdiv_op_e          req_op;
    sew_e              req_sew;
    logic [DATA_W-1:0] vs1;
    logic [DATA_W-1:0] vs2;
    logic              busy;
    logic              done;
    logic [DATA_W-1:0] vd;

    int unsigned       check_count;
    int unsigned       err_count;
    logic [31:0]       rng_state;

    vdiv_top #(.DATA_W(DATA_W)) dut0 (
        .clk_i   (clk),
        .rstn_i  (rstn),
        .valid_i (valid),
        .op_i    (req_op),
        .sew_i   (req_sew),
        .vs1_i   (vs1),
        .vs2_i   (vs2),
        .busy_o  (busy),
        .done_o  (done),
        .vd_o    (vd)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    `include "tb_vdiv_tasks.svh"

    // --------------------
    // tests
    task automatic reset_values_test();
        int unsigned chk0;
        int unsigned err0;
        chk0 = check_count;
        err0 = err_count;
        check_flag(busy, 1'b0, "busy_o after reset");
        check_flag(done, 1'b0, "done_o after reset");
        check_vec(vd, '0, "vd_o after reset");
        report_test("reset values", chk0, err0);
    endtask

    task automatic unsigned_ops_test();
        int unsigned       chk0;
        int unsigned       err0;
        sew_e              s;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        chk0 = check_count;
        err0 = err_count;
        for (int si = 0; si < 4; si++) begin
            s = sew_e'(si);
            for (int r = 0; r < ROUNDS; r++) begin
                a = rand_vec();
                b = rand_vec();
                // narrow divisors give wide quotients
                if (r % 2 == 1) begin
                    b = b & lane_pattern(s, {64{1'b1}} >> (64 - elem_bits(s) / 2), 8'hff);
                end
                run_and_check(OP_DIVU, s, b, a, "unsigned");
                run_and_check(OP_REMU, s, b, a, "unsigned");
            end
        end
        report_test("unsigned divide and remainder", chk0, err0);
    endtask

    task automatic signed_ops_test();
        int unsigned       chk0;
        int unsigned       err0;
        sew_e              s;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] even;
        chk0 = check_count;
        err0 = err_count;
        for (int si = 0; si < 4; si++) begin
            s = sew_e'(si);
            // random signs cover all four sign pairs
            for (int r = 0; r < ROUNDS; r++) begin
                a = rand_vec();
                b = rand_vec();
                if (r % 2 == 1) begin
                    b = b & lane_pattern(s, {64{1'b1}} >> (64 - elem_bits(s) / 2), 8'hff);
                end
                run_and_check(OP_DIV, s, b, a, "signed");
                run_and_check(OP_REM, s, b, a, "signed");
            end
            // even lanes hold most negative over minus one
            even = lane_pattern(s, {64{1'b1}}, 8'h55);
            a    = (rand_vec() & ~even) | lane_pattern(s, 64'd1 << (elem_bits(s) - 1), 8'h55);
            b    = rand_vec() | even;
            run_and_check(OP_DIV, s, b, a, "overflow");
            run_and_check(OP_REM, s, b, a, "overflow");
        end
        report_test("signed divide and remainder", chk0, err0);
    endtask

    task automatic div_by_zero_test();
        int unsigned       chk0;
        int unsigned       err0;
        sew_e              s;
        logic [7:0]        sel;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        chk0 = check_count;
        err0 = err_count;
        for (int si = 0; si < 4; si++) begin
            s = sew_e'(si);
            for (int v = 0; v < 2; v++) begin
                sel = (v == 0) ? 8'h55 : 8'h86;
                a   = rand_vec();
                b   = rand_vec() & ~lane_pattern(s, {64{1'b1}}, sel);
                run_and_check(OP_DIV, s, b, a, "zero divisor");
                run_and_check(OP_DIVU, s, b, a, "zero divisor");
                run_and_check(OP_REM, s, b, a, "zero divisor");
                run_and_check(OP_REMU, s, b, a, "zero divisor");
            end
        end
        report_test("divide by zero", chk0, err0);
    endtask

    task automatic latency_test();
        int unsigned       chk0;
        int unsigned       err0;
        int                cycles;
        logic              busy_held;
        sew_e              s;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        chk0 = check_count;
        err0 = err_count;
        for (int si = 0; si < 4; si++) begin
            s = sew_e'(si);
            a = rand_vec();
            b = rand_vec() | lane_pattern(s, 64'd1, 8'hff);
            issue_request(OP_DIVU, s, b, a);
            wait_done(cycles, busy_held);
            check_latency(cycles, expected_latency(s),
                          $sformatf("sew %0d done_o delay", elem_bits(s)));
            check_flag(busy_held, 1'b1, "busy_o high until done_o");
            check_flag(busy, 1'b0, "busy_o low with done_o");
            check_vec(vd, model_vec(OP_DIVU, s, b, a), "latency run result");
            @(negedge clk);
            check_flag(done, 1'b0, "done_o after one cycle");
        end
        report_test("latency", chk0, err0);
    endtask

    task automatic busy_strobe_test();
        int unsigned       chk0;
        int unsigned       err0;
        int unsigned       done_seen;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] exp_a;
        chk0 = check_count;
        err0 = err_count;
        a     = rand_vec();
        b     = rand_vec() & lane_pattern(SEW_16, 64'h00ff, 8'hff);
        exp_a = model_vec(OP_DIVU, SEW_16, b, a);
        issue_request(OP_DIVU, SEW_16, b, a);
        repeat (4) @(negedge clk);
        check_flag(busy, 1'b1, "busy_o before the second strobe");
        // this request must be dropped
        issue_request(OP_REM, SEW_8, rand_vec(), rand_vec());
        done_seen = 0;
        // long enough for a second result had the strobe been taken
        for (int c = 0; c < expected_latency(SEW_16) + expected_latency(SEW_8) + 8; c++) begin
            if (done) begin
                done_seen++;
                check_vec(vd, exp_a, "result next to the ignored strobe");
            end
            @(negedge clk);
        end
        check_flag(done_seen == 1, 1'b1, "exactly one done_o pulse");
        check_flag(busy, 1'b0, "busy_o after the only result");
        check_vec(vd, exp_a, "vd_o held after done_o");
        run_and_check(OP_REMU, SEW_32, rand_vec(), rand_vec(), "after hold");
        report_test("strobe while busy", chk0, err0);
    endtask

    // --------------------
    // main sequence
    initial begin
        clk         = 1'b0;
        rstn        = 1'b0;
        valid       = 1'b0;
        req_op      = OP_DIVU;
        req_sew     = SEW_8;
        vs1         = '0;
        vs2         = '0;
        check_count = 0;
        err_count   = 0;
        rng_state   = 32'hbbf820e3;
        repeat (RST_CYCLES) @(posedge clk);
        @(negedge clk);
        rstn = 1'b1;
        @(negedge clk);
        reset_values_test();
        unsigned_ops_test();
        signed_ops_test();
        div_by_zero_test();
        latency_test();
        busy_strobe_test();
        $display("summary: %0d checks, %0d errors", check_count, err_count);
        if (err_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // watchdog, twice the worst-case run plus margin
    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog: run did not end within %0d cycles", WATCHDOG_CYCLES);
        $display("Errors found");
        $finish;
    end

endmodule
